// File: project.f
+incdir+hw
hw/bridge_pkg.sv
hw/bridge_if.sv
hw/axi_req_capture.sv
hw/sys_bus_sequencer.sv
hw/axi_resp_gen.sv
hw/axi_gp_bridge.sv
testbench/tb_axi_gp_bridge.sv

// File: Bender.yml
package:
  name: axi_gp_bridge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/bridge_pkg.sv
      - hw/bridge_if.sv
      - hw/axi_req_capture.sv
      - hw/sys_bus_sequencer.sv
      - hw/axi_resp_gen.sv
      - hw/axi_gp_bridge.sv
  - target: test
    files:
      - testbench/tb_axi_gp_bridge.sv

// File: testbench/tb_axi_gp_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_gp_bridge;

  localparam logic [1:0]  OKAY   = 2'b00;  // axi response codes
  localparam logic [1:0]  SLVERR = 2'b10;
  localparam logic [31:0] BASE   = 32'h4000_0000;
  localparam logic [31:0] ERR_RGN   = 32'h0000_1000;  // bit 12, bus error
  localparam logic [31:0] NOACK_RGN = 32'h0000_2000;  // bit 13, never acked
  // ~75 accesses at <= 25 cycles with stalls, plus two 33 cycle ack timeouts, doubled
  localparam int MAX_CYCLES = 4000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [11:0] awid, arid;
  logic [31:0] awaddr, araddr, wdata;
  logic [3:0]  awlen, arlen, wstrb;
  logic        awvalid, wvalid, wlast, arvalid, bready, rready;
  logic [31:0] sys_rdata;
  logic        sys_err, sys_ack;
  wire         awready, wready, arready, bvalid, rvalid, rlast;
  wire         sys_rstn, sys_wen, sys_ren;
  wire  [11:0] bid, rid;
  wire  [1:0]  bresp, rresp;
  wire  [31:0] rdata, sys_addr, sys_wdata;
  wire  [3:0]  sys_sel;

  logic [31:0] shadow [64];   // reference view of the peripheral
  logic [31:0] bus_mem [64];  // peripheral model storage
  logic        exp_we [$];    // expected responses, issue order
  logic [11:0] exp_id [$];
  logic [1:0]  exp_resp [$];
  logic [31:0] exp_data [$];

  integer seed = 32'h1f7f8a38;
  integer bus_seed = 32'h1f7f8a39;  // own streams per process
  integer rdy_seed = 32'h1f7f8a3a;
  int     err_cnt = 0, check_cnt = 0, resp_cnt = 0, issue_cnt = 0;
  int     strobe_cnt = 0, cycle_cnt = 0, test_no = 0, test_err0 = 0;
  int     i, n0, bb;
  string  test_name;
  logic   stall_en = 1'b0;
  logic [31:0] rdy_rnd;       // ready stall draw
  logic   b_wait = 1'b0, r_wait = 1'b0;
  logic [11:0] b_hold_id, r_hold_id;
  logic   bus_pend = 1'b0, bus_we, bus_strobe_q = 1'b0;
  logic [31:0] bus_addr, bus_wdata;
  logic [3:0]  bus_sel;
  int     bus_delay;
  logic [11:0] t_id;
  logic [31:0] t_data, t_rnd;
  logic [3:0]  t_strb;
  logic [5:0]  idx_list [12];

  axi_gp_bridge u_axi_gp_bridge (
    .axi0_clk_i (clk),     .rst_n_i    (rst_n),
    .awid_i     (awid),    .awaddr_i   (awaddr),   .awlen_i   (awlen),
    .awvalid_i  (awvalid), .awready_o  (awready),
    .wdata_i    (wdata),   .wstrb_i    (wstrb),    .wlast_i   (wlast),
    .wvalid_i   (wvalid),  .wready_o   (wready),
    .bid_o      (bid),     .bresp_o    (bresp),    .bvalid_o  (bvalid),  .bready_i (bready),
    .arid_i     (arid),    .araddr_i   (araddr),   .arlen_i   (arlen),
    .arvalid_i  (arvalid), .arready_o  (arready),
    .rid_o      (rid),     .rdata_o    (rdata),    .rresp_o   (rresp),
    .rlast_o    (rlast),   .rvalid_o   (rvalid),   .rready_i  (rready),
    .sys_rstn_o (sys_rstn), .sys_addr_o (sys_addr), .sys_wdata_o (sys_wdata),
    .sys_sel_o  (sys_sel), .sys_wen_o  (sys_wen),  .sys_ren_o (sys_ren),
    .sys_rdata_i (sys_rdata), .sys_err_i (sys_err), .sys_ack_i (sys_ack)
  );

  initial begin
    forever #20 clk = ~clk;  // 40 ns period
  end

  // ----------------------------------------
  // reference model and helpers

  function automatic logic [31:0] fill_word(input logic [5:0] idx);
    return {~idx, 2'b10, idx, 2'b01, 8'hc3, idx, idx[1:0]};
  endfunction

  function automatic logic [31:0] word_addr(input logic [31:0] region, input logic [5:0] idx);
    return BASE | region | {24'h0, idx, 2'b00};
  endfunction

  // {resp, rdata} expected for one access, good writes update the shadow
  function automatic logic [33:0] ref_access(input logic [31:0] addr, input logic we,
                                             input logic [31:0] data, input logic [3:0] sel,
                                             input logic [3:0] len);
    int b;
    if (len != 0 || addr[13] || addr[12]) begin
      return {SLVERR, 32'h0};  // burst, no ack or bus error
    end
    if (!we) begin
      return {OKAY, shadow[addr[7:2]]};
    end
    for (b = 0; b < 4; b++) begin
      if (sel[b]) begin
        shadow[addr[7:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    return {OKAY, 32'h0};
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic push_expect(input logic we, input logic [11:0] id, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] sel,
                             input logic [3:0] len);
    logic [33:0] r;
    r = ref_access(addr, we, data, sel, len);
    exp_we.push_back(we);
    exp_id.push_back(id);
    exp_resp.push_back(r[33:32]);
    exp_data.push_back(r[31:0]);
    issue_cnt++;
  endtask

  // ----------------------------------------
  // axi master channels

  task automatic send_aw(input logic [11:0] id, input logic [31:0] addr, input logic [3:0] len);
    @(negedge clk);
    awvalid = 1'b1;
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    do @(posedge clk); while (!awready);  // transfer on this edge
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [31:0] data, input logic [3:0] strb, input logic last);
    @(negedge clk);
    wvalid = 1'b1;
    wdata  = data;
    wstrb  = strb;
    wlast  = last;
    do @(posedge clk); while (!wready);
    @(negedge clk);
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input logic [11:0] id, input logic [31:0] addr, input logic [3:0] len);
    @(negedge clk);
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    arlen   = len;
    do @(posedge clk); while (!arready);
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  // order 0 address first, 1 data first, 2 same cycle
  task automatic write_single(input logic [11:0] id, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb, input int order);
    case (order)
      0: begin
        send_aw(id, addr, 4'h0);
        send_w(data, strb, 1'b1);
      end
      1: begin
        send_w(data, strb, 1'b1);
        send_aw(id, addr, 4'h0);
      end
      default: fork
        send_aw(id, addr, 4'h0);
        send_w(data, strb, 1'b1);
      join
    endcase
    push_expect(1'b1, id, addr, data, strb, 4'h0);
  endtask

  task automatic read_single(input logic [11:0] id, input logic [31:0] addr);
    send_ar(id, addr, 4'h0);
    push_expect(1'b0, id, addr, 32'h0, 4'hf, 4'h0);
  endtask

  task automatic write_burst(input logic [11:0] id, input logic [31:0] addr, input logic [3:0] len);
    int k;
    send_aw(id, addr, len);
    for (k = 0; k <= len; k++) begin
      send_w(32'hdead_0000 | k, 4'hf, k == len);
    end
    push_expect(1'b1, id, addr, 32'h0, 4'hf, len);
  endtask

  task automatic wait_drain();
    while (exp_we.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
  endtask

  task automatic finish_test();
    test_no++;
    $display("test %0d %-30s %s, %0d errors", test_no, test_name,
             (err_cnt == test_err0) ? "ok" : "failed", err_cnt - test_err0);
  endtask

  // ----------------------------------------
  // peripheral model on the system bus

  always @(negedge clk) begin
    sys_ack   = 1'b0;
    sys_err   = 1'b0;
    sys_rdata = 32'h0;
    if (sys_wen || sys_ren) begin
      strobe_cnt++;
      if (bus_strobe_q) report_error("bus strobe held for more than one cycle");
      if (bus_pend && !bus_addr[13]) report_error("new strobe while an access is still open");
      if (sys_ren) check_equal("sys_sel_o", sys_sel, 4'hf);  // reads use the whole word
      bus_pend  = 1'b1;
      bus_we    = sys_wen;
      bus_addr  = sys_addr;
      bus_wdata = sys_wdata;
      bus_sel   = sys_sel;
      bus_delay = {$random(bus_seed)} % 6;  // 0 acks in the strobe cycle
    end
    bus_strobe_q = sys_wen || sys_ren;
    if (bus_pend && !bus_addr[13]) begin
      if (bus_delay == 0) begin
        bus_pend = 1'b0;
        sys_ack  = 1'b1;
        if (bus_addr[12]) begin
          sys_err = 1'b1;
        end else if (bus_we) begin
          for (bb = 0; bb < 4; bb++) begin
            if (bus_sel[bb]) bus_mem[bus_addr[7:2]][8*bb +: 8] = bus_wdata[8*bb +: 8];
          end
        end else begin
          sys_rdata = bus_mem[bus_addr[7:2]];
        end
      end else begin
        bus_delay--;
      end
    end
  end

  // ----------------------------------------
  // ready stalls and response compare

  always @(negedge clk) begin
    rdy_rnd = $random(rdy_seed);
    bready  = ~stall_en | rdy_rnd[0];
    rready  = ~stall_en | rdy_rnd[1];
    if (b_wait && (!bvalid || bid !== b_hold_id)) report_error("B response changed before bready");
    if (r_wait && (!rvalid || rid !== r_hold_id)) report_error("R response changed before rready");
    if (bvalid && bready) begin
      resp_cnt++;
      if (exp_we.size() == 0 || !exp_we[0]) begin
        report_error("write response arrived out of issue order");
      end else begin
        check_equal("bid_o", bid, exp_id[0]);
        check_equal("bresp_o", bresp, exp_resp[0]);
      end
    end
    if (rvalid && rready) begin
      resp_cnt++;
      if (exp_we.size() == 0 || exp_we[0]) begin
        report_error("read response arrived out of issue order");
      end else begin
        check_equal("rid_o", rid, exp_id[0]);
        check_equal("rresp_o", rresp, exp_resp[0]);
        check_equal("rdata_o", rdata, exp_data[0]);
        check_equal("rlast_o", rlast, 1'b1);
      end
    end
    if (((bvalid && bready) || (rvalid && rready)) && exp_we.size() != 0) begin
      void'(exp_we.pop_front());
      void'(exp_id.pop_front());
      void'(exp_resp.pop_front());
      void'(exp_data.pop_front());
    end
    b_wait    = bvalid && !bready;  // must hold until taken
    r_wait    = rvalid && !rready;
    b_hold_id = bid;
    r_hold_id = rid;
  end

  // watchdog
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // ----------------------------------------
  // test sequence

  initial begin
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    bready  = 1'b1;
    rready  = 1'b1;
    sys_rdata = '0;
    sys_err = 1'b0;
    sys_ack = 1'b0;
    for (i = 0; i < 64; i++) begin
      shadow[i]  = fill_word(i);
      bus_mem[i] = fill_word(i);
    end

    start_test("reset");
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_equal("awready/wready/arready/bvalid/rvalid/sys_wen/sys_ren",
                {awready, wready, arready, bvalid, rvalid, sys_wen, sys_ren}, 7'h0);
    check_equal("sys_rstn_o", sys_rstn, 1'b0);
    rst_n = 1'b1;
    #10;
    check_equal("sys_rstn_o", sys_rstn, 1'b0);  // still low until the next edge
    @(negedge clk);
    check_equal("sys_rstn_o", sys_rstn, 1'b1);  // one cycle behind rst_n_i
    finish_test();

    start_test("writes then reads");
    for (i = 0; i < 12; i++) begin
      idx_list[i] = $random(seed);
      t_id   = $random(seed);
      t_data = $random(seed);
      t_strb = $random(seed);
      write_single(t_id, word_addr(0, idx_list[i]), t_data, t_strb, 0);
    end
    for (i = 0; i < 12; i++) begin
      t_id = $random(seed);
      read_single(t_id, word_addr(0, idx_list[i]));
    end
    wait_drain();
    finish_test();

    start_test("write channel order");
    for (i = 0; i < 3; i++) begin
      t_data = $random(seed);
      write_single(12'h100 + i, word_addr(0, 40 + i), t_data, 4'hf, i);
    end
    for (i = 0; i < 3; i++) begin
      read_single(12'h200 + i, word_addr(0, 40 + i));
    end
    wait_drain();
    finish_test();

    start_test("error and no-ack regions");
    write_single(12'h301, word_addr(ERR_RGN, 5), 32'h1234_5678, 4'hf, 0);
    read_single(12'h302, word_addr(ERR_RGN, 5));
    write_single(12'h303, word_addr(NOACK_RGN, 6), 32'h8765_4321, 4'hf, 2);
    read_single(12'h304, word_addr(NOACK_RGN, 6));
    read_single(12'h305, word_addr(0, 5));  // untouched by the failed write
    wait_drain();
    finish_test();

    start_test("bursts");
    n0 = strobe_cnt;
    write_burst(12'h401, word_addr(0, 7), 4'h3);
    send_ar(12'h402, word_addr(0, 7), 4'h2);
    push_expect(1'b0, 12'h402, word_addr(0, 7), 32'h0, 4'hf, 4'h2);
    wait_drain();
    check_equal("sys_wen_o/sys_ren_o pulse count", strobe_cnt, n0);
    read_single(12'h403, word_addr(0, 7));
    wait_drain();
    finish_test();

    start_test("ready back-pressure");
    stall_en = 1'b1;
    for (i = 0; i < 24; i++) begin
      t_rnd  = $random(seed);
      t_id   = $random(seed);
      t_data = $random(seed);
      if (t_rnd[0]) begin
        write_single(t_id, word_addr(0, t_rnd[13:8]), t_data, t_rnd[7:4], {t_rnd[3:1]} % 3);
      end else begin
        read_single(t_id, word_addr(0, t_rnd[13:8]));
      end
    end
    wait_drain();
    stall_en = 1'b0;
    check_equal("response count", resp_cnt, issue_cnt);
    finish_test();

    $display("tests %0d, checks %0d, responses %0d of %0d, errors %0d",
             test_no, check_cnt, resp_cnt, issue_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/axi_gp_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module axi_gp_bridge (
  input  wire                      axi0_clk_i,  // also system clock
  input  wire                      rst_n_i,
  // axi write address
  input  wire bridge_pkg::axi_id_t  awid_i,
  input  wire bridge_pkg::addr_t    awaddr_i,
  input  wire bridge_pkg::axi_len_t awlen_i,
  input  wire                      awvalid_i,
  output wire                      awready_o,
  // axi write data
  input  wire bridge_pkg::data_t    wdata_i,
  input  wire bridge_pkg::sel_t     wstrb_i,
  input  wire                      wlast_i,
  input  wire                      wvalid_i,
  output wire                      wready_o,
  // axi write response
  output wire bridge_pkg::axi_id_t  bid_o,
  output wire bridge_pkg::resp_t    bresp_o,
  output wire                      bvalid_o,
  input  wire                      bready_i,
  // axi read address
  input  wire bridge_pkg::axi_id_t  arid_i,
  input  wire bridge_pkg::addr_t    araddr_i,
  input  wire bridge_pkg::axi_len_t arlen_i,
  input  wire                      arvalid_i,
  output wire                      arready_o,
  // axi read data
  output wire bridge_pkg::axi_id_t  rid_o,
  output wire bridge_pkg::data_t    rdata_o,
  output wire bridge_pkg::resp_t    rresp_o,
  output wire                      rlast_o,
  output wire                      rvalid_o,
  input  wire                      rready_i,
  // system bus
  output logic                     sys_rstn_o,  // registered reset, active low
  output wire bridge_pkg::addr_t    sys_addr_o,
  output wire bridge_pkg::data_t    sys_wdata_o,
  output wire bridge_pkg::sel_t     sys_sel_o,
  output wire                      sys_wen_o,
  output wire                      sys_ren_o,
  input  wire bridge_pkg::data_t    sys_rdata_i,
  input  wire                      sys_err_i,
  input  wire                      sys_ack_i
);

  sys_req_if u_req_if ();
  sys_rsp_if u_rsp_if ();

  // one flop, peripherals leave reset a cycle after the bridge
  always_ff @(posedge axi0_clk_i) begin
    sys_rstn_o <= rst_n_i;
  end

  // ----------------------------------------
  // input side

  axi_req_capture u_axi_req_capture (
    .clk_i     (axi0_clk_i),
    .rst_n_i   (rst_n_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awlen_i   (awlen_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wlast_i   (wlast_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .arlen_i   (arlen_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .req       (u_req_if)
  );

  // bus strobes and ack wait
  sys_bus_sequencer u_sys_bus_sequencer (
    .clk_i       (axi0_clk_i),
    .rst_n_i     (rst_n_i),
    .req         (u_req_if),
    .rsp         (u_rsp_if),
    .sys_addr_o  (sys_addr_o),
    .sys_wdata_o (sys_wdata_o),
    .sys_sel_o   (sys_sel_o),
    .sys_wen_o   (sys_wen_o),
    .sys_ren_o   (sys_ren_o),
    .sys_rdata_i (sys_rdata_i),
    .sys_err_i   (sys_err_i),
    .sys_ack_i   (sys_ack_i)
  );

  // b and r channels
  axi_resp_gen u_axi_resp_gen (
    .clk_i    (axi0_clk_i),
    .rst_n_i  (rst_n_i),
    .rsp      (u_rsp_if),
    .bid_o    (bid_o),
    .bresp_o  (bresp_o),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .rid_o    (rid_o),
    .rdata_o  (rdata_o),
    .rresp_o  (rresp_o),
    .rlast_o  (rlast_o),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i)
  );

endmodule

`default_nettype wire

// File: hw/axi_resp_gen.sv
`timescale 1ns/10ps
`default_nettype none

module axi_resp_gen (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  sys_rsp_if.dst              rsp,
  // write response channel
  output bridge_pkg::axi_id_t bid_o,
  output bridge_pkg::resp_t   bresp_o,
  output logic                bvalid_o,
  input  wire                 bready_i,
  // read data channel
  output bridge_pkg::axi_id_t rid_o,
  output bridge_pkg::data_t   rdata_o,
  output bridge_pkg::resp_t   rresp_o,
  output logic                rlast_o,
  output logic                rvalid_o,
  input  wire                 rready_i
);
  import bridge_pkg::*;

  logic    bvalid_q, rvalid_q;
  axi_id_t bid_q, rid_q;
  resp_t   bresp_q, rresp_q;
  data_t   rdata_q;

  // ----------------------------------------
  // valids, cleared by the matching ready

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (rsp.push) begin          // sequencer only pushes when not busy
        if (rsp.we) begin
          bvalid_q <= 1'b1;
        end else begin
          rvalid_q <= 1'b1;
        end
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i) begin
    if (rsp.push && rsp.we) begin
      bid_q   <= rsp.id;
      bresp_q <= rsp.resp;
    end
    if (rsp.push && !rsp.we) begin
      rid_q   <= rsp.id;
      rdata_q <= rsp.rdata;
      rresp_q <= rsp.resp;
    end
  end

  // ----------------------------------------
  // outputs

  assign bid_o    = bid_q;
  assign bresp_o  = bresp_q;
  assign bvalid_o = bvalid_q;

  assign rid_o    = rid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;
  assign rlast_o  = 1'b1;          // single beat, bursts answer once
  assign rvalid_o = rvalid_q;

  // one response outstanding at a time
  assign rsp.busy = bvalid_q | rvalid_q;

endmodule

`default_nettype wire

// File: hw/sys_bus_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sys_bus_sequencer (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  sys_req_if.dst                req,
  sys_rsp_if.src                rsp,
  // system bus
  output bridge_pkg::addr_t     sys_addr_o,
  output bridge_pkg::data_t     sys_wdata_o,
  output bridge_pkg::sel_t      sys_sel_o,
  output logic                  sys_wen_o,
  output logic                  sys_ren_o,
  input  wire bridge_pkg::data_t sys_rdata_i,
  input  wire                   sys_err_i,
  input  wire                   sys_ack_i
);
  import bridge_pkg::*;
  `include "bridge_consts.svh"

  localparam logic [`BRIDGE_TO_W-1:0] TO_LIMIT = `BRIDGE_ACK_TIMEOUT;

  seq_state_t              state_q, state_nxt;
  logic [`BRIDGE_TO_W-1:0] to_cnt_q;    // cycles since strobe
  logic                    strobe;
  logic                    finish;      // ack, timeout or bad request seen
  logic                    push;
  data_t                   rdata_q, fin_rdata;
  resp_t                   resp_q, fin_resp;

  // first cycle with valid, bad requests never strobe
  assign strobe = (state_q == SEQ_IDLE) & req.valid & ~req.bad;

  assign finish = ((state_q == SEQ_IDLE) & req.valid & (req.bad | sys_ack_i)) |
                  ((state_q == SEQ_WAIT_ACK) & (sys_ack_i | (to_cnt_q == TO_LIMIT)));

  assign push = (finish | (state_q == SEQ_DONE)) & ~rsp.busy;

  // ----------------------------------------
  // response value

  always_comb begin
    if (state_q == SEQ_DONE) begin
      fin_rdata = rdata_q;                 // latched while waiting
      fin_resp  = resp_q;
    end else if (req.bad) begin
      fin_rdata = '0;
      fin_resp  = `BRIDGE_RESP_SLVERR;
    end else if (sys_ack_i) begin
      fin_rdata = sys_rdata_i;
      fin_resp  = sys_err_i ? `BRIDGE_RESP_SLVERR : `BRIDGE_RESP_OKAY;
    end else begin
      fin_rdata = '0;                      // timed out
      fin_resp  = `BRIDGE_RESP_SLVERR;
    end
  end

  // next state
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      SEQ_IDLE, SEQ_WAIT_ACK: begin
        if (finish) begin
          state_nxt = push ? SEQ_IDLE : SEQ_DONE;
        end else if (strobe) begin
          state_nxt = SEQ_WAIT_ACK;
        end
      end
      SEQ_DONE: begin
        if (push) begin
          state_nxt = SEQ_IDLE;
        end
      end
      default: state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= SEQ_IDLE;
      to_cnt_q <= '0;
    end else begin
      state_q <= state_nxt;
      if (strobe) begin
        to_cnt_q <= 'd1;
      end else if (state_q == SEQ_WAIT_ACK) begin
        to_cnt_q <= to_cnt_q + 1'b1;
      end
    end
  end

  // hold result for a stalled response side
  always_ff @(posedge clk_i) begin
    if (finish) begin
      rdata_q <= fin_rdata;
      resp_q  <= fin_resp;
    end
  end

  // ----------------------------------------
  // outputs

  assign sys_addr_o  = req.addr;   // held by capture until done
  assign sys_wdata_o = req.wdata;
  assign sys_sel_o   = req.sel;
  assign sys_wen_o   = strobe & req.we;
  assign sys_ren_o   = strobe & ~req.we;

  assign req.done  = push;
  assign rsp.push  = push;
  assign rsp.we    = req.we;
  assign rsp.id    = req.id;
  assign rsp.rdata = fin_rdata;
  assign rsp.resp  = fin_resp;

endmodule

`default_nettype wire

// File: hw/axi_req_capture.sv
`timescale 1ns/10ps
`default_nettype none

module axi_req_capture (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  // write address channel
  input  wire bridge_pkg::axi_id_t  awid_i,
  input  wire bridge_pkg::addr_t    awaddr_i,
  input  wire bridge_pkg::axi_len_t awlen_i,
  input  wire                      awvalid_i,
  output logic                     awready_o,
  // write data channel
  input  wire bridge_pkg::data_t    wdata_i,
  input  wire bridge_pkg::sel_t     wstrb_i,
  input  wire                      wlast_i,
  input  wire                      wvalid_i,
  output logic                     wready_o,
  // read address channel
  input  wire bridge_pkg::axi_id_t  arid_i,
  input  wire bridge_pkg::addr_t    araddr_i,
  input  wire bridge_pkg::axi_len_t arlen_i,
  input  wire                      arvalid_i,
  output logic                     arready_o,
  // request to sequencer
  sys_req_if.src                   req
);
  import bridge_pkg::*;

  cap_state_t state_q, state_nxt;
  logic       aw_got_q, aw_got_nxt;  // write address taken
  logic       w_got_q, w_got_nxt;    // final data beat taken
  logic       awready_q, wready_q;
  logic       ar_en_q;               // read side open, idle only
  logic       aw_fire, w_fire, ar_fire;
  axi_len_t   len_now;
  axi_len_t   beat_cnt_q;            // beats seen before wlast

  // payload, no reset
  addr_t      addr_q;
  data_t      wdata_q;
  sel_t       sel_q;
  axi_id_t    id_q;
  axi_len_t   len_q;

  // pending write blocks the read so writes go first
  assign awready_o = awready_q;
  assign wready_o  = wready_q;
  assign arready_o = ar_en_q & ~awvalid_i & ~wvalid_i;

  assign aw_fire = awvalid_i & awready_o;
  assign w_fire  = wvalid_i & wready_o;
  assign ar_fire = arvalid_i & arready_o;

  assign len_now = aw_fire ? awlen_i : len_q;

  // ----------------------------------------
  // next state

  always_comb begin
    state_nxt  = state_q;
    aw_got_nxt = aw_got_q | aw_fire;
    w_got_nxt  = w_got_q | (w_fire & wlast_i);
    case (state_q)
      CAP_IDLE, CAP_WR_COLLECT: begin
        if (ar_fire) begin
          state_nxt = CAP_RD_HOLD;  // only possible from idle
        end else if (aw_got_nxt && w_got_nxt) begin
          state_nxt = CAP_WR_HOLD;
        end else if (aw_got_nxt && (len_now != '0)) begin
          state_nxt = CAP_DRAIN;    // burst, eat the rest of the beats
        end else if (aw_fire || w_fire) begin
          state_nxt = CAP_WR_COLLECT;
        end
      end
      CAP_DRAIN: begin
        if (w_got_nxt) begin
          state_nxt = CAP_WR_HOLD;
        end
      end
      CAP_RD_HOLD, CAP_WR_HOLD: begin
        if (req.done) begin
          state_nxt  = CAP_IDLE;
          aw_got_nxt = 1'b0;
          w_got_nxt  = 1'b0;
        end
      end
      default: state_nxt = CAP_IDLE;
    endcase
  end

  // ----------------------------------------
  // control regs, readys follow next state

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= CAP_IDLE;
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
      beat_cnt_q <= '0;
      awready_q  <= 1'b0;
      wready_q   <= 1'b0;
      ar_en_q    <= 1'b0;
    end else begin
      state_q   <= state_nxt;
      aw_got_q  <= aw_got_nxt;
      w_got_q   <= w_got_nxt;
      awready_q <= ((state_nxt == CAP_IDLE) || (state_nxt == CAP_WR_COLLECT)) & ~aw_got_nxt;
      wready_q  <= ((state_nxt == CAP_IDLE) || (state_nxt == CAP_WR_COLLECT) ||
                    (state_nxt == CAP_DRAIN)) & ~w_got_nxt;
      ar_en_q   <= (state_nxt == CAP_IDLE);
      if (req.done) begin
        beat_cnt_q <= '0;
      end else if (w_fire && !wlast_i) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;  // non-final beats
      end
    end
  end

  // payload capture
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      addr_q <= awaddr_i;
      id_q   <= awid_i;
      len_q  <= awlen_i;
    end
    if (ar_fire) begin
      addr_q <= araddr_i;
      id_q   <= arid_i;
      len_q  <= arlen_i;
      sel_q  <= '1;         // reads take whole word
    end
    if (w_fire) begin
      wdata_q <= wdata_i;   // only single beats reach the bus
      sel_q   <= wstrb_i;
    end
  end

  // request out, all from registers
  assign req.valid = (state_q == CAP_RD_HOLD) || (state_q == CAP_WR_HOLD);
  assign req.we    = (state_q == CAP_WR_HOLD);
  assign req.addr  = addr_q;
  assign req.wdata = wdata_q;
  assign req.sel   = sel_q;
  assign req.id    = id_q;
  assign req.bad   = (len_q != '0) || (beat_cnt_q != len_q);  // beat count vs awlen

endmodule

`default_nettype wire

// File: hw/bridge_if.sv
`timescale 1ns/10ps
`default_nettype none

// ----------------------------------------
// capture -> sequencer request

interface sys_req_if;
  import bridge_pkg::*;

  logic    valid;  // level, held until the cycle after done
  logic    we;     // 1 write, 0 read
  addr_t   addr;
  data_t   wdata;
  sel_t    sel;    // all ones for reads
  axi_id_t id;
  logic    bad;    // burst, never goes on the bus
  logic    done;   // one cycle, from sequencer

  modport src (
    output valid, we, addr, wdata, sel, id, bad,
    input  done
  );

  modport dst (
    input  valid, we, addr, wdata, sel, id, bad,
    output done
  );

endinterface

// ----------------------------------------
// sequencer -> response side

interface sys_rsp_if;
  import bridge_pkg::*;

  logic    push;   // one cycle per transaction
  logic    we;     // selects b or r channel
  data_t   rdata;
  resp_t   resp;
  axi_id_t id;
  logic    busy;   // response still waiting for the master

  modport src (
    output push, we, rdata, resp, id,
    input  busy
  );

  modport dst (
    input  push, we, rdata, resp, id,
    output busy
  );

endinterface

`default_nettype wire

// File: hw/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  `include "bridge_consts.svh"

  // bus payload types
  typedef logic [`BRIDGE_AW-1:0]   addr_t;     // byte address
  typedef logic [`BRIDGE_DW-1:0]   data_t;     // one data word
  typedef logic [`BRIDGE_DW/8-1:0] sel_t;      // byte select, one bit per lane
  typedef logic [`BRIDGE_IW-1:0]   axi_id_t;   // echoed back unchanged
  typedef logic [`BRIDGE_LW-1:0]   axi_len_t;  // beats minus one
  typedef logic [1:0]              resp_t;     // bresp / rresp encoding

  // request capture fsm
  typedef enum logic [2:0] {
    CAP_IDLE,        // nothing taken yet
    CAP_WR_COLLECT,  // one write channel in, other one pending
    CAP_RD_HOLD,     // read request presented to sequencer
    CAP_WR_HOLD,     // write request presented to sequencer
    CAP_DRAIN        // burst address in, swallowing data beats
  } cap_state_t;

  // system bus sequencer fsm
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WAIT_ACK,  // strobe issued, ack outstanding
    SEQ_DONE       // result latched, response side still busy
  } seq_state_t;

endpackage

`default_nettype wire

// File: hw/bridge_consts.svh
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// ----------------------------------------
// bus widths

`define BRIDGE_AW 32  // address
`define BRIDGE_DW 32  // data
`define BRIDGE_IW 12  // axi id as seen on the gp port
`define BRIDGE_LW 4   // axi3 burst length field

// ----------------------------------------
// axi response codes

`define BRIDGE_RESP_OKAY   2'b00
`define BRIDGE_RESP_SLVERR 2'b10

// ----------------------------------------
// acknowledge timeout

// cycles after the strobe before giving up on sys_ack_i
`define BRIDGE_ACK_TIMEOUT 32

// counter must hold the full timeout value
`define BRIDGE_TO_W 6

`endif
